// ==== design/cpu_defines.svh ====
// core-wide sizes and reset values for the MIPS pipeline
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// datapath
`define XLEN 32 // data and address width
`define REG_ADDR_BITS 5
`define REG_COUNT 32

// data memory, word addressed
`define DMEM_ADDR_BITS 8
`define DMEM_DEPTH 256

// reset contents
`define REG_INIT 32'd200 // registers 1 to 31
`define DMEM_INIT 32'd5 // every data word
`define RESET_PC 32'h0000_0000

`endif

// ==== design/isaPkg.sv ====
// instruction word types and encodings of the supported MIPS-32 subset
`default_nettype none

package isaPkg;

	typedef logic [31:0] instrT;
	typedef logic [4:0] regIdxT;

	// major opcodes, bits 31:26
	typedef enum logic [5:0] {
		OP_RTYPE = 6'd0,
		OP_J = 6'd2,
		OP_BEQ = 6'd4,
		OP_ADDI = 6'd8,
		OP_LW = 6'd35,
		OP_SW = 6'd43
	} opcodeE;

	// function field of R type, bits 5:0
	typedef enum logic [5:0] {
		F_ADD = 6'd32,
		F_SUB = 6'd34,
		F_AND = 6'd36,
		F_OR = 6'd37,
		F_SLT = 6'd42
	} functE;

	// field views of one word
	typedef struct packed {
		logic [5:0] op;
		regIdxT rs;
		regIdxT rt;
		regIdxT rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rTypeT;

	typedef struct packed {
		logic [5:0] op;
		regIdxT rs;
		regIdxT rt;
		logic [15:0] imm;
	} iTypeT;

	typedef struct packed {
		logic [5:0] op;
		logic [25:0] index;
	} jTypeT;

endpackage

`default_nettype wire

// ==== design/pipePkg.sv ====
// pipeline-internal selects and operations shared between the stages
`default_nettype none

package pipePkg;

	// operand source for the forward muxes
	typedef enum logic [1:0] {
		FWD_NONE = 2'd0, // register file value
		FWD_MEM = 2'd1, // result sitting in the memory stage
		FWD_WB = 2'd2 // result being written back
	} fwdSelE;

	// ALU operation, worked out in decode
	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR = 3'd3,
		ALU_SLT = 3'd4, // unsigned compare
		ALU_NONE = 3'd5
	} aluOpE;

	// write-back source picked in the memory stage
	typedef enum logic {
		WB_ALU = 1'b0,
		WB_LOAD = 1'b1
	} wbSelE;

endpackage

`default_nettype wire

// ==== design/fetchStage.sv ====
// fetch stage: program counter, next address and the fetch/decode register
`timescale 1ns/1ns
`default_nettype none
`include "cpu_defines.svh"

module fetchStage (
	input logic Reset,
	input logic clk,
	input logic stall,
	input logic redirect,
	input logic [`XLEN-1:0] redirectTarget,
	output logic [`XLEN-1:0] fetchAddr,
	input isaPkg::instrT fetchInstr,
	output isaPkg::instrT idInstr,
	output logic [`XLEN-1:0] idPc,
	output logic idValid
);
	import isaPkg::*;

	logic [`XLEN-1:0] pc;

	assign fetchAddr = pc; // instruction memory lives outside the core

	// pc and decode slot valid
	always_ff @(posedge Reset or posedge clk) begin
		if (clk) begin
			pc <= `RESET_PC;
			idValid <= 1'b0;
		end else begin
			if (redirect)
				pc <= redirectTarget; // taken beq or j
			else if (!stall)
				pc <= pc + 'd4;
			if (redirect)
				idValid <= 1'b0; // squash the word fetched behind the branch
			else if (!stall)
				idValid <= 1'b1;
		end
	end

	// word and its address, held while decode stalls
	always_ff @(posedge Reset) begin
		if (!stall) begin
			idInstr <= fetchInstr;
			idPc <= pc;
		end
	end

	// decode never asks for a hold and a squash of the same slot
	holdXorSquash: assert property (@(posedge Reset) disable iff (clk)
		idValid |-> !(stall && redirect))
		else $error("stall and redirect both raised for a valid decode slot");

endmodule

`default_nettype wire

// ==== design/decodeStage.sv ====
// decode stage: control, register file, early branch resolve and hazard stall
`timescale 1ns/1ns
`default_nettype none
`include "cpu_defines.svh"

module decodeStage (
	input logic Reset,
	input logic clk,
	input isaPkg::instrT idInstr,
	input logic [`XLEN-1:0] idPc,
	input logic idValid,
	output logic stall,
	output logic redirect,
	output logic [`XLEN-1:0] redirectTarget,
	input logic [`XLEN-1:0] memAddr,
	input isaPkg::regIdxT memDest,
	input logic memRegWrite,
	input logic wbValid,
	input isaPkg::regIdxT wbReg,
	input logic [`XLEN-1:0] wbData,
	output logic [`XLEN-1:0] exOperandA,
	output logic [`XLEN-1:0] exOperandB,
	output logic [`XLEN-1:0] exImm,
	output pipePkg::aluOpE exAluOp,
	output logic exUseImm,
	output isaPkg::regIdxT exRs,
	output isaPkg::regIdxT exRt,
	output isaPkg::regIdxT exDest,
	output logic exRegWrite,
	output logic exMemWrite,
	output logic exMemToReg,
	output logic exValid
);
	import isaPkg::*;
	import pipePkg::*;

	rTypeT rFields;
	iTypeT iFields;
	jTypeT jFields;
	opcodeE opcode;
	logic [`XLEN-1:0] regs [`REG_COUNT];
	logic [`XLEN-1:0] rdA;
	logic [`XLEN-1:0] rdB;
	logic [`XLEN-1:0] cmpA;
	logic [`XLEN-1:0] cmpB;
	logic [`XLEN-1:0] pcPlus4;
	logic [`XLEN-1:0] branchTarget;
	logic [`XLEN-1:0] jumpTarget;
	logic regWrite;
	logic memWrite;
	logic memToReg;
	logic useImm;
	logic isBranch;
	logic isJump;
	logic readsRs;
	logic readsRt;
	logic loadUse;
	logic branchHazard;
	logic taken;
	logic loadInMem; // a load now sits in the memory stage
	regIdxT loadInMemDest;
	regIdxT dest;
	aluOpE aluOp;

	assign rFields = idInstr;
	assign iFields = idInstr;
	assign jFields = idInstr;
	assign opcode = opcodeE'(iFields.op);

	// ----------------------------------------
	// control decode
	// ----------------------------------------
	always_comb begin
		regWrite = 1'b0;
		memWrite = 1'b0;
		memToReg = 1'b0;
		useImm = 1'b0;
		isBranch = 1'b0;
		isJump = 1'b0;
		readsRt = 1'b0;
		aluOp = ALU_NONE;
		dest = iFields.rt; // I type writes rt
		case (opcode)
			OP_RTYPE: begin
				dest = rFields.rd;
				readsRt = 1'b1;
				case (functE'(rFields.funct))
					F_ADD: aluOp = ALU_ADD;
					F_SUB: aluOp = ALU_SUB;
					F_AND: aluOp = ALU_AND;
					F_OR: aluOp = ALU_OR;
					F_SLT: aluOp = ALU_SLT;
					default: aluOp = ALU_NONE;
				endcase
				regWrite = (aluOp != ALU_NONE); // unknown funct writes nothing
			end
			OP_ADDI: begin
				regWrite = 1'b1;
				useImm = 1'b1;
				aluOp = ALU_ADD;
			end
			OP_LW: begin
				regWrite = 1'b1;
				memToReg = 1'b1;
				useImm = 1'b1;
				aluOp = ALU_ADD;
			end
			OP_SW: begin
				memWrite = 1'b1;
				useImm = 1'b1;
				readsRt = 1'b1; // store data
				aluOp = ALU_ADD;
			end
			OP_BEQ: begin
				isBranch = 1'b1;
				readsRt = 1'b1;
			end
			OP_J: isJump = 1'b1;
			default: ;
		endcase
	end

	assign readsRs = (opcode != OP_J);

	// ----------------------------------------
	// register file with write-back bypass
	// ----------------------------------------
	always_ff @(posedge Reset or posedge clk) begin
		if (clk) begin
			for (int i = 0; i < `REG_COUNT; i++)
				regs[i] <= (i == 0) ? '0 : `REG_INIT;
		end else if (wbValid) begin
			regs[wbReg] <= wbData;
		end
	end

	assign rdA = (wbValid && wbReg == iFields.rs) ? wbData : regs[iFields.rs];
	assign rdB = (wbValid && wbReg == iFields.rt) ? wbData : regs[iFields.rt];

	// newest value of a source for the beq compare
	function automatic logic [`XLEN-1:0] fwdValue(input regIdxT src,
			input logic [`XLEN-1:0] regVal);
		fwdSelE sel;
		sel = FWD_NONE;
		if (memRegWrite && memDest != '0 && memDest == src)
			sel = FWD_MEM;
		else if (wbValid && wbReg == src)
			sel = FWD_WB;
		case (sel)
			FWD_MEM: return memAddr;
			FWD_WB: return wbData;
			default: return regVal;
		endcase
	endfunction

	// does a pending write hit a source of this instruction
	function automatic logic hits(input regIdxT d);
		return d != '0 && ((readsRs && d == iFields.rs) || (readsRt && d == iFields.rt));
	endfunction

	// ----------------------------------------
	// hazards and branch resolve
	// ----------------------------------------
	always_comb begin
		cmpA = fwdValue(iFields.rs, rdA);
		cmpB = fwdValue(iFields.rt, rdB);
		loadUse = exValid && exMemToReg && hits(exDest);
		// beq needs its operands a cycle early, and a load in memory only has its address
		branchHazard = isBranch && ((exValid && exRegWrite && hits(exDest))
			|| (loadInMem && hits(loadInMemDest)));
		stall = idValid && (loadUse || branchHazard);
	end

	assign pcPlus4 = idPc + 'd4;
	assign branchTarget = pcPlus4 + {{(`XLEN-18){iFields.imm[15]}}, iFields.imm, 2'b00};
	assign jumpTarget = {pcPlus4[`XLEN-1:`XLEN-4], jFields.index, 2'b00};
	assign taken = isBranch && (cmpA == cmpB);
	assign redirect = idValid && !stall && (isJump || taken);
	assign redirectTarget = isJump ? jumpTarget : branchTarget;

	// decode/execute register, control part
	always_ff @(posedge Reset or posedge clk) begin
		if (clk) begin
			exValid <= 1'b0;
			exRegWrite <= 1'b0;
			exMemWrite <= 1'b0;
			exMemToReg <= 1'b0;
			loadInMem <= 1'b0;
		end else begin
			exValid <= idValid && !stall; // bubble on stall
			exRegWrite <= regWrite;
			exMemWrite <= memWrite;
			exMemToReg <= memToReg;
			loadInMem <= exValid && exMemToReg;
		end
	end

	// operands and fields
	always_ff @(posedge Reset) begin
		exOperandA <= rdA;
		exOperandB <= rdB;
		exImm <= {{(`XLEN-16){1'b0}}, iFields.imm}; // zero-extended on purpose
		exAluOp <= aluOp;
		exUseImm <= useImm;
		exRs <= iFields.rs;
		exRt <= iFields.rt;
		exDest <= dest;
		loadInMemDest <= exDest;
	end

	// register 0 stays zero across the whole pipe
	noWriteZero: assert property (@(posedge Reset) disable iff (clk)
		wbValid |-> wbReg != '0)
		else $error("write-back targets register 0");

endmodule

`default_nettype wire

// ==== design/executeStage.sv ====
// execute stage: operand forwarding, ALU and the execute/memory register
`timescale 1ns/1ns
`default_nettype none
`include "cpu_defines.svh"

module executeStage (
	input logic Reset,
	input logic clk,
	input logic [`XLEN-1:0] exOperandA,
	input logic [`XLEN-1:0] exOperandB,
	input logic [`XLEN-1:0] exImm,
	input pipePkg::aluOpE exAluOp,
	input logic exUseImm,
	input isaPkg::regIdxT exRs,
	input isaPkg::regIdxT exRt,
	input isaPkg::regIdxT exDest,
	input logic exRegWrite,
	input logic exMemWrite,
	input logic exMemToReg,
	input logic exValid,
	input logic wbValid,
	input isaPkg::regIdxT wbReg,
	input logic [`XLEN-1:0] wbData,
	output logic [`XLEN-1:0] memAddr,
	output logic [`XLEN-1:0] memStoreData,
	output isaPkg::regIdxT memDest,
	output logic memRegWrite,
	output logic memMemWrite,
	output logic memMemToReg,
	output logic memValid
);
	import isaPkg::*;
	import pipePkg::*;

	fwdSelE selA;
	fwdSelE selB;
	logic [`XLEN-1:0] opA;
	logic [`XLEN-1:0] opB;
	logic [`XLEN-1:0] aluB;
	logic [`XLEN-1:0] aluResult;

	// memory stage is newer than write-back, so it wins
	function automatic fwdSelE pickSrc(input regIdxT src);
		if (memRegWrite && memDest != '0 && memDest == src)
			return FWD_MEM;
		if (wbValid && wbReg == src)
			return FWD_WB;
		return FWD_NONE;
	endfunction

	always_comb begin
		selA = pickSrc(exRs);
		selB = pickSrc(exRt);
		case (selA)
			FWD_MEM: opA = memAddr;
			FWD_WB: opA = wbData;
			default: opA = exOperandA;
		endcase
		case (selB)
			FWD_MEM: opB = memAddr;
			FWD_WB: opB = wbData;
			default: opB = exOperandB;
		endcase
	end

	assign aluB = exUseImm ? exImm : opB;

	// ----------------------------------------
	// ALU
	// ----------------------------------------
	always_comb begin
		case (exAluOp)
			ALU_ADD: aluResult = opA + aluB;
			ALU_SUB: aluResult = opA - aluB;
			ALU_AND: aluResult = opA & aluB;
			ALU_OR: aluResult = opA | aluB;
			ALU_SLT: aluResult = {{(`XLEN-1){1'b0}}, opA < aluB}; // unsigned
			default: aluResult = '0;
		endcase
	end

	// execute/memory register, control qualified by valid
	always_ff @(posedge Reset or posedge clk) begin
		if (clk) begin
			memValid <= 1'b0;
			memRegWrite <= 1'b0;
			memMemWrite <= 1'b0;
			memMemToReg <= 1'b0;
		end else begin
			memValid <= exValid;
			memRegWrite <= exValid && exRegWrite;
			memMemWrite <= exValid && exMemWrite;
			memMemToReg <= exMemToReg;
		end
	end

	always_ff @(posedge Reset) begin
		memAddr <= aluResult;
		memStoreData <= opB; // sw data is the forwarded rt
		memDest <= exDest;
	end

	// decode gives every register writer a real operation
	writerHasOp: assert property (@(posedge Reset) disable iff (clk)
		exValid && exRegWrite |-> exAluOp != ALU_NONE)
		else $error("register write without an ALU operation");

endmodule

`default_nettype wire

// ==== design/memoryStage.sv ====
// memory stage: data memory, result select and the write-back register
`timescale 1ns/1ns
`default_nettype none
`include "cpu_defines.svh"

module memoryStage (
	input logic Reset,
	input logic clk,
	input logic [`XLEN-1:0] memAddr,
	input logic [`XLEN-1:0] memStoreData,
	input logic [`REG_ADDR_BITS-1:0] memDest,
	input logic memRegWrite,
	input logic memMemWrite,
	input logic memMemToReg,
	input logic memValid,
	output logic wbValid,
	output logic [`REG_ADDR_BITS-1:0] wbReg,
	output logic [`XLEN-1:0] wbData,
	output logic storeValid,
	output logic [`XLEN-1:0] storeAddr,
	output logic [`XLEN-1:0] storeData
);
	import pipePkg::*;

	logic [`XLEN-1:0] dmem [`DMEM_DEPTH];
	logic [`DMEM_ADDR_BITS-1:0] wordIdx;
	logic [`XLEN-1:0] result;
	wbSelE wbSel;

	assign wordIdx = memAddr[`DMEM_ADDR_BITS-1:0]; // word addressed, upper bits ignored

	// observed store, same cycle as the write
	assign storeValid = memValid && memMemWrite;
	assign storeAddr = memAddr;
	assign storeData = memStoreData;

	always_ff @(posedge Reset or posedge clk) begin
		if (clk) begin
			for (int i = 0; i < `DMEM_DEPTH; i++)
				dmem[i] <= `DMEM_INIT;
		end else if (storeValid) begin
			dmem[wordIdx] <= memStoreData;
		end
	end

	assign wbSel = memMemToReg ? WB_LOAD : WB_ALU;
	assign result = (wbSel == WB_LOAD) ? dmem[wordIdx] : memAddr;

	// write-back register
	always_ff @(posedge Reset or posedge clk) begin
		if (clk)
			wbValid <= 1'b0;
		else
			wbValid <= memValid && memRegWrite && memDest != '0;
	end

	always_ff @(posedge Reset) begin
		wbReg <= memDest;
		wbData <= result;
	end

	// a store never turns into a register write one cycle later
	storeNoWrite: assert property (@(posedge Reset) disable iff (clk)
		storeValid |=> !wbValid)
		else $error("store followed by a write-back of the same instruction");

endmodule

`default_nettype wire

// ==== design/mipsPipeline.sv ====
// five-stage MIPS-32 subset core with external fetch and retire ports
`timescale 1ns/1ns
`default_nettype none
`include "cpu_defines.svh"

module mipsPipeline (
	input logic Reset,
	input logic clk,
	output logic [`XLEN-1:0] fetchAddr,
	input isaPkg::instrT fetchInstr,
	output logic wbValid,
	output logic [`REG_ADDR_BITS-1:0] wbReg,
	output logic [`XLEN-1:0] wbData,
	output logic storeValid,
	output logic [`XLEN-1:0] storeAddr,
	output logic [`XLEN-1:0] storeData
);
	import isaPkg::*;
	import pipePkg::*;

	// fetch <-> decode
	instrT idInstr;
	logic [`XLEN-1:0] idPc;
	logic idValid;
	logic stall;
	logic redirect;
	logic [`XLEN-1:0] redirectTarget;

	// decode -> execute
	logic [`XLEN-1:0] exOperandA;
	logic [`XLEN-1:0] exOperandB;
	logic [`XLEN-1:0] exImm;
	aluOpE exAluOp;
	logic exUseImm;
	regIdxT exRs;
	regIdxT exRt;
	regIdxT exDest;
	logic exRegWrite;
	logic exMemWrite;
	logic exMemToReg;
	logic exValid;

	// execute -> memory, also the memory-stage forward
	logic [`XLEN-1:0] memAddr;
	logic [`XLEN-1:0] memStoreData;
	regIdxT memDest;
	logic memRegWrite;
	logic memMemWrite;
	logic memMemToReg;
	logic memValid;

	fetchStage fetchStage_inst (.*);
	decodeStage decodeStage_inst (.*);
	executeStage executeStage_inst (.*);
	memoryStage memoryStage_inst (.*);

endmodule

`default_nettype wire

// ==== verif/retireChecker.sv ====
// retire checker: in-order ISA model and assertions on write-back and store strobes
`timescale 1ns/1ns
`default_nettype none
`include "cpu_defines.svh"

module retireChecker #(
	parameter int PROG_LEN = 200
) (
	input logic Reset,
	input logic clk,
	input isaPkg::instrT prog [PROG_LEN],
	input logic progReady,
	input logic wbValid,
	input logic [`REG_ADDR_BITS-1:0] wbReg,
	input logic [`XLEN-1:0] wbData,
	input logic storeValid,
	input logic [`XLEN-1:0] storeAddr,
	input logic [`XLEN-1:0] storeData,
	output logic done,
	output logic failed
);
	import isaPkg::*;

	localparam int MAX_EV = 1024;

	logic evIsStore [MAX_EV];
	logic [`REG_ADDR_BITS-1:0] evReg [MAX_EV];
	logic [`XLEN-1:0] evAddr [MAX_EV];
	logic [`XLEN-1:0] evData [MAX_EV];
	int evCount = 0;
	int head;
	int storeSlot;
	logic modelReady = 1'b0;
	logic extraWb = 1'b0;
	logic extraStore = 1'b0;
	logic badWb = 1'b0;
	logic badStore = 1'b0;
	logic busyInReset = 1'b0;

	task automatic addEvent(input logic isStore, input regIdxT r, input logic [31:0] a,
			input logic [31:0] d);
		evIsStore[evCount] = isStore;
		evReg[evCount] = r;
		evAddr[evCount] = a;
		evData[evCount] = d;
		evCount++;
	endtask

	// ----------------------------------------
	// reference model
	// ----------------------------------------
	initial begin
		logic [31:0] regs [32];
		logic [31:0] mem [256];
		logic seen [PROG_LEN];
		logic [31:0] pc;
		logic [31:0] pcNext;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] v;
		instrT w;
		regIdxT rd;
		logic writes;
		wait (progReady);
		for (int i = 0; i < 32; i++)
			regs[i] = (i == 0) ? 32'd0 : `REG_INIT;
		for (int i = 0; i < 256; i++)
			mem[i] = `DMEM_INIT;
		for (int i = 0; i < PROG_LEN; i++)
			seen[i] = 1'b0;
		pc = `RESET_PC;
		while (pc[31:2] < 30'(PROG_LEN) && !seen[pc[31:2]]) begin
			seen[pc[31:2]] = 1'b1;
			w = prog[pc[31:2]];
			a = regs[w[25:21]];
			b = regs[w[20:16]];
			pcNext = pc + 32'd4;
			writes = 1'b0;
			rd = w[20:16];
			v = 32'd0;
			case (w[31:26])
				OP_RTYPE: begin
					rd = w[15:11];
					writes = 1'b1;
					case (w[5:0])
						F_ADD: v = a + b;
						F_SUB: v = a - b;
						F_AND: v = a & b;
						F_OR: v = a | b;
						F_SLT: v = {31'd0, a < b}; // unsigned
						default: writes = 1'b0; // empty words land here
					endcase
				end
				OP_ADDI: begin
					v = a + {16'd0, w[15:0]};
					writes = 1'b1;
				end
				OP_LW: begin
					v = mem[8'(a + {16'd0, w[15:0]})];
					writes = 1'b1;
				end
				OP_SW: begin
					mem[8'(a + {16'd0, w[15:0]})] = b;
					addEvent(1'b1, 5'd0, a + {16'd0, w[15:0]}, b);
				end
				OP_BEQ:
					if (a == b)
						pcNext = pcNext + {{14{w[15]}}, w[15:0], 2'b00};
				OP_J: pcNext = {pcNext[31:28], w[25:0], 2'b00};
				default: ;
			endcase
			if (writes && rd != 5'd0) begin
				regs[rd] = v;
				addEvent(1'b0, rd, 32'd0, v);
			end
			pc = pcNext;
		end
		modelReady = 1'b1;
	end

	// older write-back retires ahead of a store in the same cycle
	assign storeSlot = head + (wbValid ? 1 : 0);
	assign done = modelReady && head == evCount;
	assign failed = extraWb | extraStore | badWb | badStore | busyInReset;

	always @(posedge Reset or posedge clk) begin
		if (clk)
			head <= 0;
		else
			head <= storeSlot + (storeValid ? 1 : 0);
	end

	// ----------------------------------------
	// event checks
	// ----------------------------------------
	quietReset: assert property (@(posedge Reset) clk |-> !wbValid && !storeValid)
		else begin
			$display("a retire strobe appeared while the core was held in reset");
			busyInReset = 1'b1;
		end

	wbExpected: assert property (@(posedge Reset) wbValid |-> head < evCount)
		else begin
			$display("register write to r%0d arrived with no event left", $sampled(wbReg));
			extraWb = 1'b1;
		end

	wbMatch: assert property (@(posedge Reset) wbValid && head < evCount |->
			!evIsStore[head] && evReg[head] == wbReg && evData[head] == wbData)
		else begin
			$display("ERROR at %0t: write r%0d=%h, expected event %0d", $time,
				$sampled(wbReg), $sampled(wbData), $sampled(head));
			badWb = 1'b1;
		end

	storeExpected: assert property (@(posedge Reset) storeValid |-> storeSlot < evCount)
		else begin
			$display("store to %h arrived with no event left", $sampled(storeAddr));
			extraStore = 1'b1;
		end

	storeMatch: assert property (@(posedge Reset) storeValid && storeSlot < evCount |->
			evIsStore[storeSlot] && evAddr[storeSlot] == storeAddr
			&& evData[storeSlot] == storeData)
		else begin
			$display("ERROR at %0t: store [%h]=%h, expected event %0d", $time,
				$sampled(storeAddr), $sampled(storeData), $sampled(storeSlot));
			badStore = 1'b1;
		end

endmodule

`default_nettype wire

// ==== verif/mipsPipelineTb.sv ====
// testbench top for the MIPS pipeline with clock, reset, program, fetch memory and watchdog
`timescale 1ns/1ns
`default_nettype none
`include "cpu_defines.svh"

module mipsPipelineTb;
	import isaPkg::*;

	localparam int PROG_LEN = 200;
	localparam int HALF_PERIOD = 10;
	localparam int RESET_CYCLES = 16;
	localparam int LIMIT_CYCLES = 2 * (RESET_CYCLES + 3 * PROG_LEN);

	logic Reset; // clock of the core
	logic clk; // active-high async reset of the core
	logic [`XLEN-1:0] fetchAddr;
	instrT fetchInstr;
	logic wbValid;
	logic [`REG_ADDR_BITS-1:0] wbReg;
	logic [`XLEN-1:0] wbData;
	logic storeValid;
	logic [`XLEN-1:0] storeAddr;
	logic [`XLEN-1:0] storeData;
	instrT prog [PROG_LEN];
	logic progReady;
	logic done;
	logic failed;
	logic [29:0] wordIdx;
	functE functs [5];

	always #HALF_PERIOD Reset = ~Reset;

	// instruction memory answering in the same cycle
	assign wordIdx = fetchAddr[31:2];
	assign fetchInstr = (wordIdx < 30'(PROG_LEN)) ? prog[wordIdx] : '0;

	mipsPipeline mipsPipeline_inst (.*);

	retireChecker #(.PROG_LEN(PROG_LEN)) checker_inst (.*);

	// ----------------------------------------
	// instruction encoders
	// ----------------------------------------
	function automatic instrT rType(input regIdxT rs, input regIdxT rt, input regIdxT rd,
			input functE f);
		return {OP_RTYPE, rs, rt, rd, 5'd0, f};
	endfunction

	function automatic instrT iType(input opcodeE op, input regIdxT rs, input regIdxT rt,
			input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic instrT randomInstr(input int pos);
		regIdxT rs;
		regIdxT rt;
		regIdxT rd;
		int kind;
		rs = regIdxT'($urandom_range(0, 5));
		rt = regIdxT'($urandom_range(0, 5));
		rd = regIdxT'($urandom_range(0, 5));
		kind = $urandom_range(0, 9);
		case (kind)
			0, 1, 2, 3: return rType(rs, rt, rd, functs[$urandom_range(0, 4)]);
			4, 5: return iType(OP_ADDI, rs, rt, 16'($urandom));
			6: return iType(OP_LW, rs, rt, 16'($urandom_range(0, 15)));
			7: return iType(OP_SW, rs, rt, 16'($urandom_range(0, 15)));
			8: return iType(OP_BEQ, rs, rt, 16'($urandom_range(0, 3))); // forward only
			default: return {OP_J, 26'(pos + 1 + $urandom_range(0, 3))};
		endcase
	endfunction

	// directed head followed by random fill
	task automatic buildProgram();
		functs = '{F_ADD, F_SUB, F_AND, F_OR, F_SLT};
		prog[0] = iType(OP_ADDI, 5'd0, 5'd1, 16'h8001); // zero-extended imm
		prog[1] = rType(5'd1, 5'd1, 5'd2, F_ADD); // distance 1
		prog[2] = rType(5'd1, 5'd2, 5'd3, F_SUB); // distance 1 and 2
		prog[3] = rType(5'd1, 5'd3, 5'd4, F_OR); // distance 3
		prog[4] = rType(5'd1, 5'd3, 5'd5, F_SLT); // r3 has its top bit set
		prog[5] = iType(OP_SW, 5'd0, 5'd2, 16'd4);
		prog[6] = iType(OP_LW, 5'd0, 5'd6, 16'd4); // reads back the store
		prog[7] = rType(5'd6, 5'd6, 5'd7, F_ADD); // load-use
		prog[8] = iType(OP_BEQ, 5'd6, 5'd2, 16'd1); // taken
		prog[9] = iType(OP_ADDI, 5'd0, 5'd8, 16'd99); // squashed
		prog[10] = iType(OP_BEQ, 5'd1, 5'd2, 16'd1); // not taken
		prog[11] = {OP_J, 26'd13};
		prog[12] = iType(OP_ADDI, 5'd0, 5'd9, 16'd7); // squashed
		prog[13] = iType(OP_ADDI, 5'd0, 5'd10, 16'hffff);
		for (int i = 14; i < PROG_LEN; i++)
			prog[i] = randomInstr(i);
	endtask

	// fetch starts from the reset vector
	resetVector: assert property (@(posedge Reset) $fell(clk) |-> fetchAddr == `RESET_PC)
		else begin
			$display("ERROR at %0t: fetchAddr %h after reset", $time, $sampled(fetchAddr));
			$display("Simulation FAILED");
			$fatal(1, "reset vector check");
		end

	always @(posedge failed) begin
		$display("Simulation FAILED");
		$fatal(1, "retire check");
	end

	// ----------------------------------------
	// main sequence and watchdog
	// ----------------------------------------
	initial begin
		Reset = 1'b0;
		clk = 1'b1;
		progReady = 1'b0;
		void'($urandom(4711));
		buildProgram();
		progReady = 1'b1;
		repeat (RESET_CYCLES) @(posedge Reset);
		clk <= 1'b0;
		wait (done);
		repeat (10) @(posedge Reset); // room for a stray event
		if (failed) begin
			$display("Simulation FAILED");
			$fatal(1, "checker reported an error");
		end else begin
			$display("Simulation PASSED");
			$finish;
		end
	end

	initial begin
		#(LIMIT_CYCLES * 2 * HALF_PERIOD);
		$display("watchdog expired before all expected events retired");
		$display("Simulation FAILED");
		$fatal(1, "timeout");
	end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+design
design/isaPkg.sv
design/pipePkg.sv
design/fetchStage.sv
design/decodeStage.sv
design/executeStage.sv
design/memoryStage.sv
design/mipsPipeline.sv
verif/retireChecker.sv
verif/mipsPipelineTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the MIPS pipeline testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module mipsPipelineTb \
	-f all.f \
	-o simv

# nonzero exit status when the run ends in $fatal
./obj_dir/simv
